// ==== Bender.yml ====
package:
  name: alu_top

sources:
  - src/alu_pkg.sv
  - src/alu_decode.sv
  - src/exu_alu.sv
  - src/alu_stage_reg.sv
  - src/alu_top.sv
  - target: test
    files:
      - dv/alu_tb.sv

// ==== alu_top.f ====
src/alu_pkg.sv
src/alu_decode.sv
src/exu_alu.sv
src/alu_stage_reg.sv
src/alu_top.sv
dv/alu_tb.sv

// ==== dv/alu_tb.sv ====
/*
 testbench for the rv32i integer execute slice
   - clock, reset and seeded random instruction stimulus
   - reference model of the writeback triple, ordered expectation queue
   - concurrent assertions for results, stall, hold and interrupt squash
*/

`timescale 1ns/1ps

module alu_tb;

    import alu_pkg::*;

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic        wb_ready_i;
    logic        int_assert_i;
    alu_wb_t     wb_o;
    logic        alu_hold_o;

    // model state
    alu_wb_t     pipe_q[$];
    alu_wb_t     exp_wb;
    alu_wb_t     wb_prev;
    logic        check_en;
    int          write_cnt;
    int          squash_cnt;
    int          stall_cnt;

    alu_top alu_top_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .wb_ready_i   (wb_ready_i),
        .int_assert_i (int_assert_i),
        .wb_o         (wb_o),
        .alu_hold_o   (alu_hold_o)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // writeback triple before any interrupt, straight from the rv32i rules
    function automatic alu_wb_t model_wb(input logic v, input logic [31:0] ins,
                                         input logic [31:0] pc, input logic [31:0] a,
                                         input logic [31:0] b);
        alu_wb_t     w;
        logic [31:0] imm_i;
        logic [31:0] opb;
        logic [4:0]  sh;
        logic        known;
        w     = '0;
        known = 1'b1;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        opb   = (ins[6:0] == OPC_OP) ? b : imm_i;
        sh    = opb[4:0];
        case (ins[6:0])
            OPC_OP, OPC_OP_IMM: begin
                case (ins[14:12])
                    3'b000: begin
                        if (ins[6:0] == OPC_OP && ins[30]) begin
                            w.result = a - opb;
                        end else begin
                            w.result = a + opb;
                        end
                    end
                    3'b001: w.result = a << sh;
                    3'b010: w.result = {31'b0, $signed(a) < $signed(opb)};
                    3'b011: w.result = {31'b0, a < opb};
                    3'b100: w.result = a ^ opb;
                    3'b101: begin
                        if (ins[30]) begin
                            w.result = $signed(a) >>> sh;
                        end else begin
                            w.result = a >> sh;
                        end
                    end
                    3'b110: w.result = a | opb;
                    default: w.result = a & opb;
                endcase
            end
            OPC_LUI:   w.result = {ins[31:12], 12'h0};
            OPC_AUIPC: w.result = pc + {ins[31:12], 12'h0};
            // link value only
            OPC_JAL, OPC_JALR: w.result = pc + 32'd4;
            default:   known = 1'b0;
        endcase
        w.waddr = ins[11:7];
        w.we    = v && known && (ins[11:7] != 5'd0);
        return w;
    endfunction

    // one entry per accepted instruction, head is the one in execute
    always @(posedge clk) begin : model_p
        alu_wb_t head;
        if (reset_i) begin
            pipe_q.delete();
            // execute stage holds a cleared request after reset
            pipe_q.push_back('0);
            exp_wb   <= '0;
            check_en <= 1'b0;
        end else begin
            check_en <= 1'b1;
            if (!wb_ready_i && wb_o.we) begin
                stall_cnt++;
            end
            if (wb_ready_i) begin
                head = pipe_q.pop_front();
                if (int_assert_i) begin
                    if (head.we) begin
                        squash_cnt++;
                    end
                    head = '0;
                end else if (head.we) begin
                    write_cnt++;
                end
                exp_wb <= head;
                pipe_q.push_back(model_wb(instr_valid_i, instr_i, pc_i,
                                          rs1_data_i, rs2_data_i));
            end
        end
        wb_prev <= wb_o;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    wb_match_a: assert property (@(posedge clk) check_en |-> (wb_o == exp_wb))
        else begin
            $display("Fail %0t wb_o expected %h got %h", $time, $sampled(exp_wb),
                     $sampled(wb_o));
            abort_run();
        end

    // a modelled write waiting on a stalled port
    hold_a: assert property (@(posedge clk)
        check_en |-> (alu_hold_o == (exp_wb.we && !wb_ready_i)))
        else begin
            $display("Fail %0t alu_hold_o expected %b got %b", $time,
                     $sampled(exp_wb.we && !wb_ready_i), $sampled(alu_hold_o));
            abort_run();
        end

    // frozen pipe keeps the writeback triple
    stall_stable_a: assert property (@(posedge clk)
        (check_en && !wb_ready_i) |=> (wb_o == wb_prev))
        else begin
            $display("Fail %0t wb_o expected %h got %h", $time, $sampled(wb_prev),
                     $sampled(wb_o));
            abort_run();
        end

    squash_a: assert property (@(posedge clk)
        (check_en && wb_ready_i && int_assert_i) |=> (wb_o == '0))
        else begin
            $display("Fail %0t wb_o expected %h got %h", $time, '0, $sampled(wb_o));
            abort_run();
        end

    no_x0_write_a: assert property (@(posedge clk)
        (check_en && wb_o.we) |-> (wb_o.waddr != 5'd0))
        else begin
            $display("Fail %0t wb_o.waddr expected nonzero got %h", $time,
                     $sampled(wb_o.waddr));
            abort_run();
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // class 6 gives an opcode the slice does not handle
    function automatic logic [31:0] make_instr(input int cls, input logic [4:0] rd);
        logic [2:0]  f3;
        logic        b30;
        logic [11:0] imm;
        logic [31:0] w;
        f3  = 3'($urandom_range(7));
        b30 = 1'($urandom_range(1));
        imm = 12'($urandom);
        case (cls)
            0: w = {1'b0, b30, 5'b0, 5'($urandom), 5'($urandom), f3, rd, OPC_OP};
            1: begin
                // shift immediates keep funct7 clean except bit 30 on srai
                if (f3 == 3'b001) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, b30, 5'b0, imm[4:0]};
                end
                w = {imm, 5'($urandom), f3, rd, OPC_OP_IMM};
            end
            2: w = {20'($urandom), rd, OPC_LUI};
            3: w = {20'($urandom), rd, OPC_AUIPC};
            4: w = {20'($urandom), rd, OPC_JAL};
            5: w = {imm, 5'($urandom), 3'b000, rd, OPC_JALR};
            default: w = {25'($urandom), 7'b1110011};
        endcase
        return w;
    endfunction

    // mix of negatives, small values and full random for mixed-sign compares
    function automatic logic [31:0] pick_data();
        case ($urandom_range(3))
            0: return 32'h8000_0000 | 32'($urandom);
            1: return 32'($urandom_range(15));
            default: return 32'($urandom);
        endcase
    endfunction

    task automatic drive(input logic v, input logic [31:0] ins, input logic [31:0] a,
                         input logic [31:0] b, input logic rdy, input logic irq);
        @(posedge clk);
        instr_valid_i <= v;
        instr_i       <= ins;
        pc_i          <= 32'($urandom) & ~32'h3;
        rs1_data_i    <= a;
        rs2_data_i    <= b;
        wb_ready_i    <= rdy;
        int_assert_i  <= irq;
    endtask

    task automatic random_cycle(input int stall_pct, input int irq_pct);
        int         cls;
        logic [4:0] rd;
        logic       v;
        cls = $urandom_range(6);
        rd  = ($urandom_range(9) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
        v   = ($urandom_range(9) != 0);
        drive(v, make_instr(cls, rd), pick_data(), pick_data(),
              $urandom_range(99) >= stall_pct, $urandom_range(99) < irq_pct);
    endtask

    // every shift amount for sll, srl and sra, register and immediate forms
    task automatic shift_sweep();
        logic [2:0] f3;
        logic       b30;
        for (int sh = 0; sh < 32; sh++) begin
            for (int k = 0; k < 3; k++) begin
                f3  = (k == 0) ? 3'b001 : 3'b101;
                b30 = (k == 2);
                drive(1'b1, {1'b0, b30, 5'b0, 5'd2, 5'd1, f3, 5'd5, OPC_OP},
                      32'h8000_0000 | 32'($urandom), {27'($urandom), 5'(sh)},
                      1'b1, 1'b0);
                drive(1'b1, {1'b0, b30, 5'b0, 5'(sh), 5'd1, f3, 5'd6, OPC_OP_IMM},
                      pick_data(), 32'($urandom), 1'b1, 1'b0);
            end
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'ha068));
        clk           = 1'b0;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        wb_ready_i    = 1'b1;
        int_assert_i  = 1'b0;
        write_cnt     = 0;
        squash_cnt    = 0;
        stall_cnt     = 0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // clean pipe first, then shifts, then stalls and interrupts
        for (int i = 0; i < 300; i++) begin
            random_cycle(0, 0);
        end
        shift_sweep();
        for (int i = 0; i < 400; i++) begin
            random_cycle(20, 10);
        end

        // idle cycles until the last accepted write has left wb_o
        cycles = 0;
        do begin
            drive(1'b0, '0, '0, '0, 1'b1, 1'b0);
            @(negedge clk);
            cycles++;
        end while ((wb_o.we || exp_wb.we || pipe_q[0].we) && cycles < 16);
        if (wb_o.we || exp_wb.we || pipe_q[0].we) begin
            $display("timeout: pipe did not drain after %0d cycles", cycles);
            abort_run();
        end

        $display("writes %0d squashed %0d stalled %0d", write_cnt, squash_cnt, stall_cnt);
        if (write_cnt == 0 || squash_cnt == 0 || stall_cnt == 0) begin
            $display("stimulus missed writes, interrupt squashes or stalls");
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== src/alu_decode.sv ====
/*
 rv32i decode for the integer execute slice
   - one-hot operation from opcode, funct3 and funct7 bit 5
   - operand build for op, op-imm, lui, auipc, jal and jalr
   - valid qualification, x0 destinations never write
*/

`timescale 1ns/1ps

module alu_decode (
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      rs1_data_i,
    input  logic [31:0]      rs2_data_i,
    output alu_pkg::alu_req_t req_o
);

    import alu_pkg::*;

    // instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_b5;
    logic [4:0]  rd;

    // immediates
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    // decode results
    alu_op_t     op;
    logic [31:0] op1;
    logic [31:0] op2;
    logic        known_opc;

    assign opcode    = instr_i[6:0];
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // i-type, sign extended; shamt sits in the low 5 bits
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    // u-type, low 12 bits zero
    assign imm_u = {instr_i[31:12], 12'b0};

    ////////////////////////////////////////////////////////////////////////////
    // funct3 to one-hot op
    ////////////////////////////////////////////////////////////////////////////

    function automatic alu_op_t funct_op(
        input logic [2:0] f3,
        input logic       f7_b5,
        input logic       reg_form
    );
        alu_op_t o;
        o = '0;
        case (f3)
            F3_ADD: begin
                // sub only exists in the register form
                if (reg_form && f7_b5) begin
                    o.sub = 1'b1;
                end else begin
                    o.add = 1'b1;
                end
            end
            F3_SLL:  o.sll    = 1'b1;
            F3_SLT:  o.slt    = 1'b1;
            F3_SLTU: o.sltu   = 1'b1;
            F3_XOR:  o.xor_op = 1'b1;
            F3_SR: begin
                // srai is marked by the same funct7 bit
                if (f7_b5) begin
                    o.sra = 1'b1;
                end else begin
                    o.srl = 1'b1;
                end
            end
            F3_OR:   o.or_op  = 1'b1;
            default: o.and_op = 1'b1;
        endcase
        return o;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // operation and operand select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        op        = '0;
        op1       = rs1_data_i;
        op2       = rs2_data_i;
        known_opc = 1'b1;
        case (opcode)
            OPC_OP: begin
                op = funct_op(funct3, funct7_b5, 1'b1);
            end
            OPC_OP_IMM: begin
                op  = funct_op(funct3, funct7_b5, 1'b0);
                op2 = imm_i;
            end
            OPC_LUI: begin
                // result is op2 as is
                op.lui = 1'b1;
                op1    = '0;
                op2    = imm_u;
            end
            OPC_AUIPC: begin
                op.auipc = 1'b1;
                op1      = pc_i;
                op2      = imm_u;
            end
            OPC_JAL, OPC_JALR: begin
                // link value only, target computed elsewhere
                op.jump = 1'b1;
                op1     = pc_i;
                op2     = LINK_OFFSET;
            end
            default: begin
                known_opc = 1'b0;
            end
        endcase
    end

    // x0 destination drops the write
    assign req_o.valid = instr_valid_i & known_opc & (rd != 5'd0);
    assign req_o.op    = op;
    assign req_o.op1   = op1;
    assign req_o.op2   = op2;
    assign req_o.rd    = rd;

endmodule

// ==== src/alu_pkg.sv ====
/*
 shared definitions for the rv32i integer execute slice
   - major opcode and funct3 constants
   - alu_op_t   one-hot alu operation
   - alu_req_t  decoded request handed from decode to execute
   - alu_wb_t   registered writeback triple
*/

package alu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // major opcodes, instr[6:0]
    ////////////////////////////////////////////////////////////////////////////

    // register-register arithmetic
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    // register-immediate arithmetic
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    // upper immediates
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    // jumps, only the link value is produced here
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    ////////////////////////////////////////////////////////////////////////////
    // funct3 codes, shared by the op and op-imm forms
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // srl and sra, split by funct7 bit 5
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // link value is pc plus one instruction
    localparam logic [31:0] LINK_OFFSET = 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////

    // one bit per operation, never more than one set
    typedef struct packed {
        logic add;
        logic sub;
        logic sll;
        logic slt;
        logic sltu;
        logic xor_op;
        logic srl;
        logic sra;
        logic or_op;
        logic and_op;
        logic lui;
        logic auipc;
        logic jump;
    } alu_op_t;

    // request from decode, held by the first stage register
    typedef struct packed {
        logic        valid;
        alu_op_t     op;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [4:0]  rd;
    } alu_req_t;

    // writeback triple towards the register file
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] result;
    } alu_wb_t;

endpackage

// ==== src/alu_stage_reg.sv ====
/*
 pipeline stage register
   - payload type set by the instantiating level
   - synchronous active-high clear, load enable
*/

`timescale 1ns/1ps

module alu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     load_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // clear to zero, load when enabled, otherwise hold
    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

    // a frozen stage keeps its contents for the next cycle
    hold_stable_a: assert property (
        @(posedge clk) disable iff (reset_i)
        (!$past(load_i) && !$past(reset_i)) |-> $stable(q_o)
    ) else $error("alu_stage_reg: payload changed without load");

endmodule

// ==== src/alu_top.sv ====
/*
 rv32i integer execute slice, top level
   - decode, request stage, alu, writeback stage
   - both stages load on wb_ready_i, freeze together otherwise
   - alu_hold_o flags a pending write while stalled
*/

`timescale 1ns/1ps

module alu_top (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      rs1_data_i,
    input  logic [31:0]      rs2_data_i,
    input  logic             wb_ready_i,
    input  logic             int_assert_i,
    output alu_pkg::alu_wb_t wb_o,
    output logic             alu_hold_o
);

    import alu_pkg::*;

    // decode output, not yet registered
    alu_req_t dec_req;
    // request seen by the alu
    alu_req_t exe_req;
    // alu output, registered into wb_o
    alu_wb_t  exe_wb;

    alu_decode u_decode (
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .req_o        (dec_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // two stages, one load enable for the whole pipe
    ////////////////////////////////////////////////////////////////////////////

    alu_stage_reg #(
        .payload_t(alu_req_t)
    ) u_req_reg (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (wb_ready_i),
        .d_i    (dec_req),
        .q_o    (exe_req)
    );

    alu_stage_reg #(
        .payload_t(alu_wb_t)
    ) u_wb_reg (
        .clk    (clk),
        .reset_i(reset_i),
        .load_i (wb_ready_i),
        .d_i    (exe_wb),
        .q_o    (wb_o)
    );

    // interrupt is taken at the execute stage
    exu_alu u_alu (
        .clk         (clk),
        .req_i       (exe_req),
        .int_assert_i(int_assert_i),
        .wb_o        (exe_wb)
    );

    // write waiting on a busy writeback port
    assign alu_hold_o = wb_o.we & ~wb_ready_i;

endmodule

// ==== src/exu_alu.sv ====
/*
 integer alu for the execute stage
   - one left shifter, right shifts by bit reversal, sra by sign mask
   - one 33-bit adder for add, sub, compares, auipc and link
   - logic unit and gated one-hot result or
   - interrupt squash of the writeback triple
*/

`timescale 1ns/1ps

module exu_alu (
    input  logic              clk,
    input  alu_pkg::alu_req_t req_i,
    input  logic              int_assert_i,
    output alu_pkg::alu_wb_t  wb_o
);

    import alu_pkg::*;

    // request fields
    alu_op_t     op;
    logic [31:0] op1;
    logic [31:0] op2;

    assign op  = req_i.op;
    assign op1 = req_i.op1;
    assign op2 = req_i.op2;

    // operation groups, used for operand gating
    logic op_shift;
    logic op_right;
    logic op_compare;
    logic adder_op;
    logic adder_inv;

    assign op_shift   = op.sll | op.srl | op.sra;
    assign op_right   = op.srl | op.sra;
    assign op_compare = op.slt | op.sltu;
    assign adder_op   = op.add | op.sub | op_compare | op.auipc | op.jump;
    // a - b as a + ~b + 1
    assign adder_inv  = op.sub | op_compare;

    // bit 0 to bit 31 and back
    function automatic logic [31:0] bit_rev(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // shifter
    ////////////////////////////////////////////////////////////////////////////

    logic [31:0] shift_in;
    logic [4:0]  shamt;
    logic [31:0] shift_res;
    logic [31:0] sign_mask;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;

    // inputs held at zero unless a shift is requested
    assign shift_in  = {32{op_shift}} & (op_right ? bit_rev(op1) : op1);
    assign shamt     = {5{op_shift}} & op2[4:0];
    assign shift_res = shift_in << shamt;

    assign sll_res   = shift_res;
    // reverse back for the logical right shift
    assign srl_res   = bit_rev(shift_res);
    // upper shamt bits take the sign
    assign sign_mask = ~(32'hffff_ffff >> shamt);
    assign sra_res   = srl_res | ({32{op1[31]}} & sign_mask);

    ////////////////////////////////////////////////////////////////////////////
    // adder and compare
    ////////////////////////////////////////////////////////////////////////////

    logic [31:0] adder_in1;
    logic [31:0] adder_in2;
    logic        adder_cin;
    logic [32:0] adder_res;
    logic        lt_signed;
    logic        lt_unsigned;

    assign adder_in1 = {32{adder_op}} & op1;
    assign adder_in2 = {32{adder_op}} & (adder_inv ? ~op2 : op2);
    assign adder_cin = adder_op & adder_inv;
    assign adder_res = {1'b0, adder_in1} + {1'b0, adder_in2} + {32'b0, adder_cin};

    // signs differ: op1 negative means less
    // signs equal: difference sign decides
    assign lt_signed   = (op1[31] ^ op2[31]) ? op1[31] : adder_res[31];
    // no carry out of a - b means a borrow
    assign lt_unsigned = ~adder_res[32];

    ////////////////////////////////////////////////////////////////////////////
    // logic unit and result select
    ////////////////////////////////////////////////////////////////////////////

    logic [31:0] alu_res;

    assign alu_res =
        ({32{op.add | op.sub | op.auipc | op.jump}} & adder_res[31:0]) |
        ({32{op.xor_op}} & (op1 ^ op2)) |
        ({32{op.or_op}}  & (op1 | op2)) |
        ({32{op.and_op}} & (op1 & op2)) |
        ({32{op.sll}}    & sll_res) |
        ({32{op.srl}}    & srl_res) |
        ({32{op.sra}}    & sra_res) |
        ({32{op.slt}}    & {31'b0, lt_signed}) |
        ({32{op.sltu}}   & {31'b0, lt_unsigned}) |
        ({32{op.lui}}    & op2);

    // interrupt clears the whole triple
    assign wb_o.we     = req_i.valid & ~int_assert_i;
    assign wb_o.waddr  = int_assert_i ? 5'd0 : req_i.rd;
    assign wb_o.result = {32{~int_assert_i}} & alu_res;

    // decode must never hand over two operations at once
    op_onehot_a: assert property (@(posedge clk) $onehot0(req_i.op))
        else $error("exu_alu: more than one alu operation selected");

endmodule
